/* jag_mem_pkg.sv */
`default_nettype none

package jag_mem_pkg;

////////////////////////////////////////////////////////////////////////////
// Data bus

	// Full resolved bus, four DRAM lanes wide
	localparam int DATA_W = 64;

	localparam int LANE_W = 16;                  // One DRAM chip
	localparam int LANES  = DATA_W / LANE_W;     // Lanes on the board

////////////////////////////////////////////////////////////////////////////
// DRAM addressing

	// Multiplexed row/column pins
	localparam int MA_W = 10;

	localparam int COL_W   = 8;                  // Low pins at CAS
	localparam int ROW_W   = MA_W;               // All pins at RAS

	// Cell index inside one lane, column on top
	localparam int DRAM_AW = COL_W + ROW_W;

////////////////////////////////////////////////////////////////////////////
// System address and boot ROM

	localparam int SYS_AW = 24;

	// Mask address pins from the chip
	localparam int MASKA_W = 3;

	// System bits 11..3 on top of the mask pins
	localparam int ROM_AW = 12;

	localparam string ROM_FILE = "boot_rom.mem"; // Hex, one byte per line

endpackage

`default_nettype wire

/* boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_rom
	import jag_mem_pkg::*;
(
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic [SYS_AW-1:0]  sys_a,
	input  logic [MASKA_W-1:0] maska,
	input  logic               rom_cs_n,
	input  logic               oe_n0,
	output logic [7:0]         rom_q,
	output logic               rom_drive
);

	logic [7:0]        rom_mem [0:(1<<ROM_AW)-1];
	logic [ROM_AW-1:0] rom_a;
	logic              rom_live;

	// Contents come from the hex image
	initial
	begin
		$readmemh(ROM_FILE, rom_mem);
	end

	// Chip supplies the byte select, system bus the rest
	assign rom_a = {sys_a[ROM_AW-1:MASKA_W], maska};

	// Registered read, one cycle from address
	always_ff @(posedge sys_clk)
	begin
		rom_q <= rom_mem[rom_a];
	end

	// Held off the bus until the first clock out of reset
	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
			rom_live <= 1'b0;
		else
			rom_live <= 1'b1;
	end

	assign rom_drive = rom_live & ~rom_cs_n & ~oe_n0;   // Both selects low

endmodule

`default_nettype wire

/* dram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_bank
	import jag_mem_pkg::*;
(
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic [MA_W-1:0]    ma,
	input  logic               ras_n,
	input  logic               cas_n,
	input  logic [2*LANES-1:0] we_n,      // Lower/upper pair per lane
	input  logic [2:0]         oe_n,
	input  logic [DATA_W-1:0]  d_bus,
	output wire  [DATA_W-1:0]  lane_q,
	output wire  [LANES-1:0]   lane_drive
);

////////////////////////////////////////////////////////////////////////////
// Strobe history, shared by all lanes

	logic               ras_q;
	logic               cas_q;
	logic               ras_fall;
	logic               cas_fall;
	logic [ROW_W-1:0]   row_r;
	logic               col_vld;
	logic [DRAM_AW-1:0] cell_a;
	logic [LANES-1:0]   lane_oe_n;

	// Falling edges as seen on sys_clk
	assign ras_fall = ~ras_n & ras_q;
	assign cas_fall = ~cas_n & cas_q;

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ras_q   <= 1'b1;
			cas_q   <= 1'b1;
			col_vld <= 1'b0;
		end
		else
		begin
			ras_q <= ras_n;
			cas_q <= cas_n;
			if (cas_n)
				col_vld <= 1'b0;          // Cycle over
			else if (cas_fall)
				col_vld <= 1'b1;          // Column latched this edge
		end
	end

	// Row address, taken once per RAS cycle
	always_ff @(posedge sys_clk)
	begin
		if (ras_fall)
			row_r <= ma;
	end

	// Column from the low pins, live at the CAS edge
	assign cell_a = {ma[COL_W-1:0], row_r};

	// Lanes 2 and 3 share one output enable
	assign lane_oe_n = {oe_n[2], oe_n[2], oe_n[1], oe_n[0]};

////////////////////////////////////////////////////////////////////////////
// Lane arrays

	genvar k;
	generate
		for (k = 0; k < LANES; k++)
		begin : g_lane
			logic [LANE_W-1:0] mem [0:(1<<DRAM_AW)-1];
			logic [LANE_W-1:0] rd_word;
			logic              lw_n;
			logic              uw_n;

			assign lw_n = we_n[2*k];
			assign uw_n = we_n[2*k+1];

			// Byte writes and the read word share the CAS edge
			always_ff @(posedge sys_clk)
			begin
				if (cas_fall)
				begin
					if (!lw_n)
						mem[cell_a][LANE_W/2-1:0] <= d_bus[k*LANE_W +: LANE_W/2];
					if (!uw_n)
						mem[cell_a][LANE_W-1:LANE_W/2] <=
							d_bus[k*LANE_W+LANE_W/2 +: LANE_W/2];
					rd_word <= mem[cell_a];   // Held until next CAS fall
				end
			end

			assign lane_q[k*LANE_W +: LANE_W] = rd_word;

			// Read cycle only, never during a write strobe
			assign lane_drive[k] = ~lane_oe_n[k] & ~cas_n & col_vld & lw_n & uw_n;
		end
	endgenerate

endmodule

`default_nettype wire

/* bus_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_resolver
	import jag_mem_pkg::*;
(
	input  logic              ba,          // Chip owns the bus
	input  logic [SYS_AW-1:0] tom_a,
	input  logic [SYS_AW-1:0] cpu_a,
	input  logic              cpu_wr,
	input  logic [1:0]        cpu_be,
	input  logic [LANE_W-1:0] cpu_wd,
	input  logic [DATA_W-1:0] tom_d,
	input  logic [7:0]        rom_q,
	input  logic              rom_drive,
	input  logic [DATA_W-1:0] lane_q,
	input  logic [LANES-1:0]  lane_drive,
	output logic [SYS_AW-1:0] sys_a,
	output logic              sys_rw_n,
	output logic [DATA_W-1:0] d_bus
);

	logic cpu_lo;
	logic cpu_hi;

////////////////////////////////////////////////////////////////////////////
// Address and direction

	// CPU owns the bus while ba is low
	assign sys_a    = ba ? tom_a : cpu_a;
	assign sys_rw_n = ba ? 1'b1 : ~cpu_wr;

	// CPU write byte strobes
	assign cpu_lo = cpu_wr & cpu_be[0] & ~ba;
	assign cpu_hi = cpu_wr & cpu_be[1] & ~ba;

////////////////////////////////////////////////////////////////////////////
// Data bus merge

	always_comb
	begin
		// Chip drive fills whatever nobody else claims
		d_bus = tom_d;

		// Byte 0, the ROM sits between CPU and lane 0
		if (cpu_lo)
			d_bus[7:0] = cpu_wd[7:0];
		else if (rom_drive)
			d_bus[7:0] = rom_q;
		else if (lane_drive[0])
			d_bus[7:0] = lane_q[7:0];

		// Byte 1
		if (cpu_hi)
			d_bus[15:8] = cpu_wd[15:8];
		else if (lane_drive[0])
			d_bus[15:8] = lane_q[15:8];

		// Upper lanes only see DRAM or chip
		for (int i = 1; i < LANES; i++)
		begin
			if (lane_drive[i])
				d_bus[i*LANE_W +: LANE_W] = lane_q[i*LANE_W +: LANE_W];
		end
	end

endmodule

`default_nettype wire

/* jag_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module jag_mem_top
	import jag_mem_pkg::*;
(
	input  logic               sys_clk,
	input  logic               rst_n,

	// Video/object chip side
	input  logic [SYS_AW-1:0]  tom_a,
	input  logic [DATA_W-1:0]  tom_d,
	input  logic [MA_W-1:0]    ma,
	input  logic [MASKA_W-1:0] maska,
	input  logic               ras_n,
	input  logic               cas_n,
	input  logic [2*LANES-1:0] we_n,
	input  logic [2:0]         oe_n,
	input  logic               rom_cs_n,
	input  logic               ba,

	// CPU side
	input  logic [SYS_AW-1:0]  cpu_a,
	input  logic               cpu_wr,
	input  logic [1:0]         cpu_be,
	input  logic [LANE_W-1:0]  cpu_wd,

	// Resolved board buses
	output wire  [SYS_AW-1:0]  sys_a,
	output wire                sys_rw_n,
	output wire  [DATA_W-1:0]  d_bus,
	output wire  [LANES-1:0]   lane_drive,
	output wire                rom_drive
);

	wire [7:0]        rom_q;
	wire [DATA_W-1:0] lane_q;

////////////////////////////////////////////////////////////////////////////
// Memories

	// ROM addressed from the resolved system bus
	boot_rom u_boot_rom
	(
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.sys_a     (sys_a),
		.maska     (maska),
		.rom_cs_n  (rom_cs_n),
		.oe_n0     (oe_n[0]),      // Shared with lane 0
		.rom_q     (rom_q),
		.rom_drive (rom_drive)
	);

	// DRAM writes whatever ends up on the resolved bus
	dram_bank u_dram_bank
	(
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.ma         (ma),
		.ras_n      (ras_n),
		.cas_n      (cas_n),
		.we_n       (we_n),
		.oe_n       (oe_n),
		.d_bus      (d_bus),
		.lane_q     (lane_q),
		.lane_drive (lane_drive)
	);

////////////////////////////////////////////////////////////////////////////
// Bus glue

	bus_resolver u_bus_resolver
	(
		.ba         (ba),
		.tom_a      (tom_a),
		.cpu_a      (cpu_a),
		.cpu_wr     (cpu_wr),
		.cpu_be     (cpu_be),
		.cpu_wd     (cpu_wd),
		.tom_d      (tom_d),
		.rom_q      (rom_q),
		.rom_drive  (rom_drive),
		.lane_q     (lane_q),
		.lane_drive (lane_drive),
		.sys_a      (sys_a),
		.sys_rw_n   (sys_rw_n),
		.d_bus      (d_bus)
	);

endmodule

`default_nettype wire

/* jag_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module jag_mem_checker
	import jag_mem_pkg::*;
(
	input  wire                sys_clk,
	input  wire                chk,          // Expected values valid
	input  wire [127:0]        chk_name,
	input  wire [DATA_W-1:0]   exp_d,
	input  wire [SYS_AW-1:0]   exp_a,
	input  wire                exp_rw_n,
	input  wire [LANES-1:0]    exp_lane,
	input  wire                exp_rom,
	input  wire [DATA_W-1:0]   d_bus,
	input  wire [SYS_AW-1:0]   sys_a,
	input  wire                sys_rw_n,
	input  wire [LANES-1:0]    lane_drive,
	input  wire                rom_drive,
	output int                 n_chk,
	output int                 n_err
);

	initial
	begin
		n_chk = 0;
		n_err = 0;
	end

	task automatic compare(input string what, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
		begin
			n_err = n_err + 1;
			$display("[ERROR] %0s %0s expected %0h actual %0h", chk_name, what, exp, act);
		end
	endtask

////////////////////////////////////////////////////////////////////////////
// Sample in the last CAS-low cycle of each entry

	always @(posedge sys_clk)
	begin
		if (chk)
		begin
			n_chk = n_chk + 1;
			compare("d_bus", exp_d, d_bus);
			compare("sys_a", DATA_W'(exp_a), DATA_W'(sys_a));
			compare("sys_rw_n", DATA_W'(exp_rw_n), DATA_W'(sys_rw_n));
			compare("lane_drive", DATA_W'(exp_lane), DATA_W'(lane_drive));
			compare("rom_drive", DATA_W'(exp_rom), DATA_W'(rom_drive));
		end
	end

endmodule

`default_nettype wire

/* jag_mem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module jag_mem_assert
	import jag_mem_pkg::*;
(
	input wire               sys_clk,
	input wire               rst_n,
	input wire [2*LANES-1:0] we_n,
	input wire [LANES-1:0]   lane_drive,
	input wire               rom_drive,
	input wire               ba,
	input wire [SYS_AW-1:0]  sys_a,
	input wire [SYS_AW-1:0]  tom_a
);

	logic [LANES-1:0] lane_wr;   // Either byte strobe low
	int               n_fail = 0;

	always_comb
	begin
		for (int k = 0; k < LANES; k++)
			lane_wr[k] = ~we_n[2*k] | ~we_n[2*k+1];
	end

	a_reset_quiet : assert property (@(posedge sys_clk)
		!rst_n |-> (lane_drive == '0 && !rom_drive))
		else
		begin
			n_fail++;
			$error("Memory drives the bus while reset is asserted");
		end

	a_no_drive_on_write : assert property (@(posedge sys_clk)
		disable iff (!rst_n) (lane_drive & lane_wr) == '0)
		else
		begin
			n_fail++;
			$error("DRAM lane drives the bus during its own write strobe");
		end

	a_chip_addr : assert property (@(posedge sys_clk) ba |-> sys_a == tom_a)
		else
		begin
			n_fail++;
			$error("System address does not follow the chip while it owns the bus");
		end

endmodule

// Top level holds both the DRAM drives and the resolved address
bind jag_mem_top jag_mem_assert u_jag_mem_assert
(
	.sys_clk    (sys_clk),
	.rst_n      (rst_n),
	.we_n       (we_n),
	.lane_drive (lane_drive),
	.rom_drive  (rom_drive),
	.ba         (ba),
	.sys_a      (sys_a),
	.tom_a      (tom_a)
);

`default_nettype wire

/* jag_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module jag_mem_tb;
	import jag_mem_pkg::*;

	localparam int CLK_NS  = 40;
	localparam int RST_CYC = 10;
	localparam int SEQ_CYC = 6;         // Clocks per table entry
	localparam int MAX_ENT = 32;

	localparam logic [2:0] K_WRITE = 3'd0;
	localparam logic [2:0] K_READ  = 3'd1;
	localparam logic [2:0] K_ROM   = 3'd2;
	localparam logic [2:0] K_CPU   = 3'd3;
	localparam logic [2:0] K_IDLE  = 3'd4;   // No RAS/CAS cycle

	typedef struct packed {
		logic [127:0]       name;
		logic [2:0]         kind;
		logic [ROW_W-1:0]   row;
		logic [COL_W-1:0]   col;
		logic [2*LANES-1:0] we_n;
		logic [2:0]         oe_n;
		logic               rom_cs_n;
		logic               ba;
		logic [SYS_AW-1:0]  tom_a;
		logic [DATA_W-1:0]  tom_d;
		logic [MASKA_W-1:0] maska;
		logic [SYS_AW-1:0]  cpu_a;
		logic               cpu_wr;
		logic [1:0]         cpu_be;
		logic [LANE_W-1:0]  cpu_wd;
		logic [DATA_W-1:0]  exp_d;
		logic [SYS_AW-1:0]  exp_a;
		logic               exp_rw_n;
		logic [LANES-1:0]   exp_lane;
		logic               exp_rom;
	} entry_t;

	logic               sys_clk;
	logic               rst_n;
	logic [SYS_AW-1:0]  tom_a;
	logic [DATA_W-1:0]  tom_d;
	logic [MA_W-1:0]    ma;
	logic [MASKA_W-1:0] maska;
	logic               ras_n;
	logic               cas_n;
	logic [2*LANES-1:0] we_n;
	logic [2:0]         oe_n;
	logic               rom_cs_n;
	logic               ba;
	logic [SYS_AW-1:0]  cpu_a;
	logic               cpu_wr;
	logic [1:0]         cpu_be;
	logic [LANE_W-1:0]  cpu_wd;
	wire  [SYS_AW-1:0]  sys_a;
	wire                sys_rw_n;
	wire  [DATA_W-1:0]  d_bus;
	wire  [LANES-1:0]   lane_drive;
	wire                rom_drive;

	// Published expectations
	logic               chk;
	logic [127:0]       chk_name;
	logic [DATA_W-1:0]  exp_d;
	logic [SYS_AW-1:0]  exp_a;
	logic               exp_rw_n;
	logic [LANES-1:0]   exp_lane;
	logic               exp_rom;
	int                 n_chk;
	int                 n_err;
	int                 n_asrt;

	entry_t             tbl [0:MAX_ENT-1];
	entry_t             cur;
	int                 n_ent;
	int                 seed;
	logic               table_ready;
	logic [7:0]         rom_img [0:(1<<ROM_AW)-1];
	logic [LANE_W-1:0]  model_mem [int];    // Lane words by lane and cell

	jag_mem_top u_jag_mem_top
	(
		.sys_clk (sys_clk), .rst_n (rst_n), .tom_a (tom_a), .tom_d (tom_d),
		.ma (ma), .maska (maska), .ras_n (ras_n), .cas_n (cas_n), .we_n (we_n),
		.oe_n (oe_n), .rom_cs_n (rom_cs_n), .ba (ba), .cpu_a (cpu_a),
		.cpu_wr (cpu_wr), .cpu_be (cpu_be), .cpu_wd (cpu_wd), .sys_a (sys_a),
		.sys_rw_n (sys_rw_n), .d_bus (d_bus), .lane_drive (lane_drive),
		.rom_drive (rom_drive)
	);

	jag_mem_checker u_checker
	(
		.sys_clk (sys_clk), .chk (chk), .chk_name (chk_name), .exp_d (exp_d),
		.exp_a (exp_a), .exp_rw_n (exp_rw_n), .exp_lane (exp_lane),
		.exp_rom (exp_rom), .d_bus (d_bus), .sys_a (sys_a), .sys_rw_n (sys_rw_n),
		.lane_drive (lane_drive), .rom_drive (rom_drive), .n_chk (n_chk),
		.n_err (n_err)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #(CLK_NS/2) sys_clk = ~sys_clk;
	end

////////////////////////////////////////////////////////////////////////////
// Reference model

	function automatic int cell_key(input int k, input logic [COL_W-1:0] col,
		input logic [ROW_W-1:0] row);
		return k * (1 << DRAM_AW) + int'({col, row});
	endfunction

	function automatic logic [LANE_W-1:0] read_model(input int k,
		input logic [COL_W-1:0] col, input logic [ROW_W-1:0] row);
		int key;
		key = cell_key(k, col, row);
		if (model_mem.exists(key))
			return model_mem[key];
		return 'x;
	endfunction

	task automatic new_entry(input logic [127:0] name, input logic [2:0] kind,
		input logic [ROW_W-1:0] row, input logic [COL_W-1:0] col);
		cur          = '0;
		cur.name     = name;
		cur.kind     = kind;
		cur.row      = row;
		cur.col      = col;
		cur.we_n     = '1;
		cur.oe_n     = '1;
		cur.rom_cs_n = 1'b1;
		cur.ba       = 1'b1;              // Chip owns the bus by default
		cur.tom_a    = $random(seed);
		cur.tom_d    = {$random(seed), $random(seed)};
		cur.cpu_a    = $random(seed);
		cur.cpu_wd   = $random(seed);
	endtask

	task automatic store_entry();
		logic [DATA_W-1:0] bus;
		logic [LANES-1:0]  oe_lane;
		logic [LANES-1:0]  drv;
		logic              cyc;
		int                key;

		oe_lane      = {cur.oe_n[2], cur.oe_n[2], cur.oe_n[1], cur.oe_n[0]};
		cyc          = (cur.kind != K_IDLE);
		cur.exp_a    = cur.ba ? cur.tom_a : cur.cpu_a;
		cur.exp_rw_n = cur.ba | ~cur.cpu_wr;
		cur.exp_rom  = ~cur.rom_cs_n & ~cur.oe_n[0];

		// Lowest priority first, later sources overwrite
		bus = cur.tom_d;
		for (int k = 0; k < LANES; k++)
		begin
			drv[k] = cyc & ~oe_lane[k] & cur.we_n[2*k] & cur.we_n[2*k+1];
			if (drv[k])
				bus[k*LANE_W +: LANE_W] = read_model(k, cur.col, cur.row);
		end
		if (cur.exp_rom)
			bus[7:0] = rom_img[{cur.exp_a[ROM_AW-1:MASKA_W], cur.maska}];
		if (cur.cpu_wr && !cur.ba && cur.cpu_be[0])
			bus[7:0] = cur.cpu_wd[7:0];
		if (cur.cpu_wr && !cur.ba && cur.cpu_be[1])
			bus[15:8] = cur.cpu_wd[15:8];
		cur.exp_d    = bus;
		cur.exp_lane = drv;

		// DRAM takes its write bytes from the resolved bus
		for (int b = 0; b < 2*LANES; b++)
		begin
			key = cell_key(b / 2, cur.col, cur.row);
			if (cyc && !cur.we_n[b])
			begin
				if (!model_mem.exists(key))
					model_mem[key] = 'x;
				model_mem[key][(b % 2)*8 +: 8] = bus[b*8 +: 8];
			end
		end
		tbl[n_ent] = cur;
		n_ent++;
	endtask

	task automatic dram_write(input logic [127:0] name, input logic [ROW_W-1:0] row,
		input logic [COL_W-1:0] col, input logic [2*LANES-1:0] wen);
		new_entry(name, K_WRITE, row, col);
		cur.we_n = wen;
		store_entry();
	endtask

	task automatic dram_read(input logic [127:0] name, input logic [ROW_W-1:0] row,
		input logic [COL_W-1:0] col, input logic [2:0] oe);
		new_entry(name, K_READ, row, col);
		cur.oe_n = oe;
		store_entry();
	endtask

	task automatic rom_read(input logic [127:0] name, input logic [SYS_AW-1:0] addr,
		input logic [MASKA_W-1:0] mask, input logic chip);
		new_entry(name, K_ROM, 10'h015, 8'h03);
		cur.ba       = chip;
		cur.tom_a    = chip ? addr : cur.tom_a;
		cur.cpu_a    = chip ? cur.cpu_a : addr;
		cur.maska    = mask;
		cur.rom_cs_n = 1'b0;
		cur.oe_n     = 3'b110;            // Lane 0 shares the ROM enable
		store_entry();
	endtask

	task automatic idle_pins();
		ras_n    = 1'b1;
		cas_n    = 1'b1;
		we_n     = '1;
		oe_n     = '1;
		rom_cs_n = 1'b1;
		cpu_wr   = 1'b0;
		cpu_be   = '0;
	endtask

////////////////////////////////////////////////////////////////////////////
// Stimulus table

	task automatic build_table();
		new_entry("after_reset", K_IDLE, '0, '0);
		store_entry();
		dram_write("wr_a", 10'h015, 8'h03, 8'h00);
		dram_write("wr_b", 10'h3a2, 8'hc4, 8'h00);
		dram_write("wr_c", 10'h200, 8'hff, 8'h00);
		dram_write("wr_d", 10'h0ff, 8'h80, 8'h00);
		dram_read("rd_a", 10'h015, 8'h03, 3'b000);
		dram_read("rd_b", 10'h3a2, 8'hc4, 3'b000);
		dram_read("rd_c", 10'h200, 8'hff, 3'b000);
		dram_read("rd_d", 10'h0ff, 8'h80, 3'b000);
		dram_write("byte_a", 10'h015, 8'h03, 8'hed);   // Lane 0 upper, lane 2 lower
		dram_write("byte_b", 10'h3a2, 8'hc4, 8'h7b);   // Lane 1 lower, lane 3 upper
		dram_read("rd_a_byte", 10'h015, 8'h03, 3'b000);
		dram_read("rd_b_byte", 10'h3a2, 8'hc4, 3'b000);
		rom_read("rom_0", 24'h000000, 3'd0, 1'b1);
		rom_read("rom_5", 24'h7f0006, 3'd5, 1'b1);     // Low address bits replaced
		rom_read("rom_13", 24'h5a300c, 3'd5, 1'b1);
		rom_read("rom_cpu_a", 24'h000008, 3'd2, 1'b0);

		// CPU write over ROM and lane 0
		new_entry("cpu_over_rom", K_CPU, 10'h015, 8'h03);
		cur.ba       = 1'b0;
		cur.cpu_wr   = 1'b1;
		cur.cpu_be   = 2'b11;
		cur.rom_cs_n = 1'b0;
		cur.oe_n     = 3'b110;
		store_entry();

		new_entry("cpu_wr_dram", K_CPU, 10'h200, 8'hff);
		cur.ba     = 1'b0;
		cur.cpu_wr = 1'b1;
		cur.cpu_be = 2'b01;
		cur.we_n   = 8'hfc;
		store_entry();

		new_entry("cpu_hi_read", K_CPU, 10'h3a2, 8'hc4);
		cur.ba     = 1'b0;
		cur.cpu_wr = 1'b1;
		cur.cpu_be = 2'b10;
		cur.oe_n   = 3'b110;
		store_entry();

		dram_read("rd_c_cpu", 10'h200, 8'hff, 3'b000);
		new_entry("chip_idle", K_IDLE, 10'h0ff, 8'h80);
		cur.oe_n = 3'b000;
		store_entry();
		dram_read("chip_lane1", 10'h0ff, 8'h80, 3'b101);
	endtask

////////////////////////////////////////////////////////////////////////////
// Main sequence

	initial
	begin
		seed        = 32'h85eb_a46c;
		n_ent       = 0;
		n_asrt      = 0;
		table_ready = 1'b0;
		rst_n       = 1'b0;
		tom_a       = '0;
		tom_d       = '0;
		ma          = '0;
		maska       = '0;
		ba          = 1'b1;
		cpu_a       = '0;
		cpu_wd      = '0;
		chk         = 1'b0;
		chk_name    = '0;
		exp_d       = '0;
		exp_a       = '0;
		exp_rw_n    = 1'b1;
		exp_lane    = '0;
		exp_rom     = 1'b0;
		idle_pins();
		rom_cs_n    = 1'b0;                  // Selects active through reset
		oe_n        = '0;
		cas_n       = 1'b0;
		$readmemh(ROM_FILE, rom_img);
		build_table();
		table_ready = 1'b1;

		repeat (RST_CYC) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;
		idle_pins();

		for (int i = 0; i < n_ent; i++)
		begin
			@(negedge sys_clk);
			ba       = tbl[i].ba;
			tom_a    = tbl[i].tom_a;
			tom_d    = tbl[i].tom_d;
			maska    = tbl[i].maska;
			cpu_a    = tbl[i].cpu_a;
			cpu_wr   = tbl[i].cpu_wr;
			cpu_be   = tbl[i].cpu_be;
			cpu_wd   = tbl[i].cpu_wd;
			we_n     = tbl[i].we_n;
			oe_n     = tbl[i].oe_n;
			rom_cs_n = tbl[i].rom_cs_n;
			ma       = tbl[i].row;
			ras_n    = (tbl[i].kind == K_IDLE);
			@(negedge sys_clk);
			ma       = MA_W'(tbl[i].col);
			cas_n    = (tbl[i].kind == K_IDLE);
			repeat (2) @(negedge sys_clk);
			chk_name = tbl[i].name;                  // Last CAS-low cycle
			exp_d    = tbl[i].exp_d;
			exp_a    = tbl[i].exp_a;
			exp_rw_n = tbl[i].exp_rw_n;
			exp_lane = tbl[i].exp_lane;
			exp_rom  = tbl[i].exp_rom;
			chk      = 1'b1;
			@(negedge sys_clk);
			chk = 1'b0;
			idle_pins();
			@(negedge sys_clk);
		end

		@(negedge sys_clk);
		n_asrt = u_jag_mem_top.u_jag_mem_assert.n_fail;
		$display("Checks run: %0d of %0d, errors: %0d, assertion failures: %0d",
			n_chk, n_ent, n_err, n_asrt);
		if (n_chk != n_ent)
			$display("Checker did not see every table entry");
		if (n_err == 0 && n_asrt == 0 && n_chk == n_ent)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog, twice the nominal table length plus reset
	initial
	begin
		longint limit_ns;
		wait (table_ready);
		limit_ns = longint'(n_ent) * SEQ_CYC * CLK_NS * 2 + RST_CYC * CLK_NS;
		#(limit_ns);
		$display("Timeout: test sequence did not finish within %0d ns", limit_ns);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
jag_mem_pkg.sv
boot_rom.sv
dram_bank.sv
bus_resolver.sv
jag_mem_top.sv
jag_mem_checker.sv
jag_mem_assert.sv
jag_mem_tb.sv

/* boot_rom.mem */
// One hex byte per line, ROM addresses 000 to 00f in order
a5
3c
7e
01
f0
5a
c3
99
12
e4
6d
b8
07
4f
d1
2e
